// File: verilog/desc_fetch_config.svh
// descriptor fetch configuration

`ifndef DESC_FETCH_CONFIG_SVH
`define DESC_FETCH_CONFIG_SVH

// ********************
// address and data widths
// ********************

// byte address width on the memory read port
`define DF_ADDR_WIDTH 32

// one memory word holds exactly one descriptor
`define DF_WORD_WIDTH 128

// byte step between consecutive descriptors of a block
`define DF_DESC_BYTES 16

// ********************
// descriptor buffer
// ********************

`define DF_FIFO_DEPTH_LOG2 4  // 16 entries, half of it bounds the reads in flight

`endif

// File: verilog/desc_fetch_pkg.sv
// descriptor fetch types

`include "desc_fetch_config.svh"

package desc_fetch_pkg;

  typedef logic [`DF_ADDR_WIDTH-1:0] desc_addr_t;           // byte address in host memory
  typedef logic [`DF_WORD_WIDTH-1:0] desc_word_t;           // raw word as read from memory
  typedef logic [7:0] block_count_t;                        // descriptors left in a block
  typedef logic [15:0] timeout_t;                           // retry delay in clock cycles
  typedef logic [`DF_FIFO_DEPTH_LOG2:0] fifo_count_t;       // one extra bit so full fits

  // descriptor layout, first field sits in the top bits of the word
  typedef struct packed {
    desc_addr_t   next_descriptor;  // start of the next block, only meaningful in the first
    logic [31:0]  source;
    logic [31:0]  length;
    logic [14:0]  control;          // handed to the dispatcher untouched
    logic         owned_by_hw;      // host clears this to mark the end of the chain
    block_count_t block_size;       // further descriptors after the first one
    logic [7:0]   format;           // bit 0 flags the first descriptor of a block
  } descriptor_t;

  // read request toward memory, held until waitrequest drops
  typedef struct packed {
    logic       read;
    desc_addr_t address;
  } mem_rd_req_t;

  // read response, one per accepted read and in order
  typedef struct packed {
    logic       readdatavalid;
    desc_word_t readdata;
  } mem_rd_rsp_t;

  typedef enum logic [2:0] {
    idle,          // disabled, or waiting to be enabled
    load_counter,  // one cycle to copy the next block address into the address counter
    load_first,    // single read of the first descriptor of a block
    load_rest,     // back-to-back reads of the remaining descriptors
    retry_wait,    // end of chain seen, timer running before the block is read again
    wait_reload    // end of chain seen, host must supply a new block address
  } fetch_state_t;

endpackage

// File: verilog/desc_fifo.sv
// descriptor FIFO

`timescale 1ns/100ps

`include "desc_fetch_config.svh"

module desc_fifo
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush,             // drops everything buffered
  input  logic                        push,
  input  desc_fetch_pkg::descriptor_t push_data,
  input  logic                        descriptor_ready,  // dispatcher side
  output desc_fetch_pkg::descriptor_t descriptor,
  output logic                        descriptor_valid,
  output desc_fetch_pkg::fifo_count_t fill_count
);

  import desc_fetch_pkg::*;

  localparam int depth = 1 << `DF_FIFO_DEPTH_LOG2;

  descriptor_t mem [depth];  // storage, read combinationally at the head

  logic [`DF_FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [`DF_FIFO_DEPTH_LOG2-1:0] rd_ptr;
  fifo_count_t count;
  logic full;
  logic wr_en;
  logic rd_en;

  assign full  = count[`DF_FIFO_DEPTH_LOG2];  // top bit alone means 16 entries
  assign wr_en = push & ~full;                // the fetch throttle keeps this from biting
  assign rd_en = descriptor_valid & descriptor_ready;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
  end

  // ********************
  // pointers and level
  // ********************

  always_ff @(posedge clk)
  begin
    if (reset | flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en & ~rd_en)
        count <= count + fifo_count_t'(1);
      else if (~wr_en & rd_en)
        count <= count - fifo_count_t'(1);
    end
  end

  // show-ahead, a word written into an empty FIFO is at the head one cycle later
  assign descriptor       = mem[rd_ptr];
  assign descriptor_valid = (count != '0);
  assign fill_count       = count;

endmodule

// File: verilog/desc_fetch_ctrl.sv
// descriptor fetch controller

`timescale 1ns/100ps

`include "desc_fetch_config.svh"

module desc_fetch_ctrl
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush,              // clears the walk like reset does
  input  logic                        enable_fetch,
  input  desc_fetch_pkg::desc_addr_t  new_location,       // host supplied block address
  input  logic                        load_new_location,
  input  desc_fetch_pkg::timeout_t    descriptor_timeout,
  input  logic                        enable_timeout,     // retry on end of chain instead of waiting
  input  logic                        waitrequest,
  input  desc_fetch_pkg::mem_rd_rsp_t rd_rsp,
  input  desc_fetch_pkg::fifo_count_t fill_count,         // fill level of the descriptor FIFO
  output desc_fetch_pkg::mem_rd_req_t rd_req,
  output logic                        push,
  output desc_fetch_pkg::descriptor_t push_data,
  output desc_fetch_pkg::fifo_count_t outstanding_reads,
  output logic                        fetch_idle
);

  import desc_fetch_pkg::*;

  // throttle point, half of the FIFO depth
  localparam fifo_count_t half_depth = fifo_count_t'(1 << (`DF_FIFO_DEPTH_LOG2 - 1));
  localparam desc_addr_t desc_step = desc_addr_t'(`DF_DESC_BYTES);

  fetch_state_t state;
  desc_addr_t   address_counter;  // address of the read being raised
  desc_addr_t   next_address;     // start of the block to walk next
  block_count_t block_counter;    // reads still to issue in load_rest
  logic         first_read_done;  // the single load_first read has been accepted
  logic         read_active;
  fifo_count_t  read_count;
  timeout_t     retry_timer;
  descriptor_t  rsp_desc;

  logic rd_fire;
  logic first_rsp;
  logic first_valid;
  logic end_of_chain;
  logic last_rest_read;
  logic too_many;
  logic go_idle;
  logic set_read;
  logic clear_read;

  // ********************
  // response decode
  // ********************

  always_comb
  begin
    rsp_desc.next_descriptor = rd_rsp.readdata[127:96];
    rsp_desc.source          = rd_rsp.readdata[95:64];
    rsp_desc.length          = rd_rsp.readdata[63:32];
    rsp_desc.control         = rd_rsp.readdata[31:17];
    rsp_desc.owned_by_hw     = rd_rsp.readdata[16];
    rsp_desc.block_size      = rd_rsp.readdata[15:8];
    rsp_desc.format          = rd_rsp.readdata[7:0];
  end

  assign rd_fire = rd_req.read & ~waitrequest;

  // responses come back in order, so with only the first read left in flight
  // the word arriving now must be the first descriptor of the block
  assign first_rsp = (state == load_first) & first_read_done & rd_rsp.readdatavalid &
                     (read_count == fifo_count_t'(1));
  assign first_valid  = first_rsp & rsp_desc.owned_by_hw;
  assign end_of_chain = first_rsp & ~rsp_desc.owned_by_hw;

  assign last_rest_read = (block_counter == block_count_t'(1));
  assign too_many = (read_count >= half_depth) | (fill_count >= half_depth);
  assign go_idle  = ~enable_fetch & (~rd_req.read | ~waitrequest);  // let a raised read land first

  // ********************
  // fetch FSM
  // ********************

  always_ff @(posedge clk)
  begin
    if (reset | flush)
      state <= idle;
    else if (go_idle)
      state <= idle;
    else
    begin
      case (state)
        idle:
          if (enable_fetch)
            state <= load_counter;  // host has stored the first block address by now
        load_counter:
          state <= load_first;
        load_first:
          if (end_of_chain)
            state <= enable_timeout ? retry_wait : wait_reload;
          else if (first_valid & (rsp_desc.block_size == '0))
            state <= load_counter;  // single descriptor block, go straight to the next one
          else if (first_valid)
            state <= load_rest;
        load_rest:
          if (rd_fire & last_rest_read)
            state <= load_counter;  // last read of the block accepted
        retry_wait:
          if (retry_timer >= descriptor_timeout)
            state <= load_counter;  // next_address still points at the same block
        wait_reload:
          if (load_new_location)
            state <= load_counter;
        default:
          state <= idle;
      endcase
    end
  end

  // ********************
  // addresses and counters
  // ********************

  always_ff @(posedge clk)
  begin
    if (load_new_location)
      next_address <= new_location;
    else if (first_valid)
      next_address <= rsp_desc.next_descriptor;  // link is known as soon as the first word lands
    if (state == load_counter)
      address_counter <= next_address;
    else if (first_valid | ((state == load_rest) & rd_fire))
      address_counter <= address_counter + desc_step;
  end

  always_ff @(posedge clk)
  begin
    if (reset | flush)
      block_counter <= '0;
    else if (first_valid)
      block_counter <= rsp_desc.block_size;
    else if ((state == load_rest) & rd_fire)
      block_counter <= block_counter - block_count_t'(1);
  end

  // reads still on the bus are counted through flush so that late responses balance out
  always_ff @(posedge clk)
  begin
    if (reset)
      read_count <= '0;
    else
    begin
      case ({rd_fire, rd_rsp.readdatavalid})
        2'b10:   read_count <= read_count + fifo_count_t'(1);
        2'b01:   read_count <= read_count - fifo_count_t'(1);
        default: read_count <= read_count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset | flush | (state != retry_wait))
      retry_timer <= '0;  // starts from 0 on the first retry_wait cycle
    else
      retry_timer <= retry_timer + timeout_t'(1);
  end

  // ********************
  // read request
  // ********************

  assign set_read = ((state == load_first) & ~first_read_done & ~too_many) |
                    ((state == load_rest) & ~too_many);
  // once accepted, a read is dropped when throttling, on the last of a block, or in load_first
  assign clear_read = rd_fire & ((state == load_first) |
                                 ((state == load_rest) & (too_many | last_rest_read)));

  always_ff @(posedge clk)
  begin
    if (reset | flush | state == load_counter)
      first_read_done <= 1'b0;
    else if ((state == load_first) & rd_fire)
      first_read_done <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset | flush | go_idle | clear_read)
      read_active <= 1'b0;  // clearing wins over setting
    else if (set_read)
      read_active <= 1'b1;
  end

  assign rd_req.read    = read_active;
  assign rd_req.address = address_counter;

  // words returning after a disable belong to an abandoned walk and are dropped
  assign push      = rd_rsp.readdatavalid & rsp_desc.owned_by_hw & (state != idle);
  assign push_data = rsp_desc;

  assign outstanding_reads = read_count;
  assign fetch_idle = (state == idle) | (state == wait_reload);

endmodule

// File: verilog/desc_fetch_top.sv
// descriptor fetch engine top

`timescale 1ns/100ps

module desc_fetch_top
(
  input  logic                        clk,
  input  logic                        reset,
  // memory read master
  output desc_fetch_pkg::mem_rd_req_t rd_req,
  input  logic                        waitrequest,
  input  desc_fetch_pkg::mem_rd_rsp_t rd_rsp,
  // descriptor stream to the dispatcher
  output desc_fetch_pkg::descriptor_t descriptor,
  output logic                        descriptor_valid,
  input  logic                        descriptor_ready,
  // host controls and status
  input  logic                        enable_fetch,
  input  logic                        flush,
  input  desc_fetch_pkg::desc_addr_t  new_location,
  input  logic                        load_new_location,
  input  desc_fetch_pkg::timeout_t    descriptor_timeout,
  input  logic                        enable_timeout,
  output desc_fetch_pkg::fifo_count_t outstanding_reads,
  output desc_fetch_pkg::fifo_count_t descriptor_fill_level,
  output logic                        fetch_idle
);

  import desc_fetch_pkg::*;

  logic        push;
  descriptor_t push_data;
  fifo_count_t fill_count;  // also throttles the reads in the controller

  desc_fetch_ctrl ctrl0
  (
    .clk(clk), .reset(reset), .flush(flush), .enable_fetch(enable_fetch),
    .new_location(new_location), .load_new_location(load_new_location),
    .descriptor_timeout(descriptor_timeout), .enable_timeout(enable_timeout),
    .waitrequest(waitrequest), .rd_rsp(rd_rsp), .fill_count(fill_count),
    .rd_req(rd_req), .push(push), .push_data(push_data),
    .outstanding_reads(outstanding_reads), .fetch_idle(fetch_idle)
  );

  desc_fifo fifo0
  (
    .clk(clk), .reset(reset), .flush(flush), .push(push), .push_data(push_data),
    .descriptor_ready(descriptor_ready), .descriptor(descriptor),
    .descriptor_valid(descriptor_valid), .fill_count(fill_count)
  );

  assign descriptor_fill_level = fill_count;

endmodule

// File: verification/tb_mem_model.sv
// memory read model

`timescale 1ns/100ps

module tb_mem_model
(
  input  logic                        clk,
  input  logic                        stall,        // random bit, holds the read off this cycle
  input  desc_fetch_pkg::mem_rd_req_t rd_req,
  output logic                        waitrequest,
  output desc_fetch_pkg::mem_rd_rsp_t rd_rsp
);

  import desc_fetch_pkg::*;

  localparam int rsp_delay = 3;  // cycles from acceptance to readdatavalid

  desc_word_t  words [desc_addr_t];  // sparse, only written addresses exist
  mem_rd_rsp_t pipe [rsp_delay];     // responses on their way back, oldest at the top
  mem_rd_rsp_t fetched;

  // an address nobody wrote gives a pattern of the whole address, never owned by hardware
  function automatic desc_word_t read_word(input desc_addr_t a);
    desc_word_t w;
    if (words.exists(a))
      w = words[a];
    else
      w = {a, ~a, a ^ 32'h5a5a_a5a5, a} & ~(desc_word_t'(1) << 16);
    return w;
  endfunction

  task automatic write_word(input desc_addr_t a, input desc_word_t w);
    words[a] = w;
  endtask

  assign waitrequest = stall;

  initial
  begin
    for (int i = 0; i < rsp_delay; i++)
      pipe[i] = '0;
    rd_rsp = '0;
  end

  always @(posedge clk)
  begin
    fetched.readdatavalid = rd_req.read & ~waitrequest;  // taken at the edge, as the DUT sees it
    fetched.readdata      = read_word(rd_req.address);
    #0.5;
    for (int i = rsp_delay - 1; i > 0; i--)
      pipe[i] = pipe[i - 1];
    pipe[0] = fetched;
    rd_rsp  = pipe[rsp_delay - 1];  // in order, one word per accepted read
  end

endmodule

// File: verification/desc_fetch_tb.sv
// descriptor fetch testbench

`timescale 1ns/100ps

`include "desc_fetch_config.svh"

module desc_fetch_tb;

  import desc_fetch_pkg::*;

  localparam int num_tests  = 6;
  localparam int wait_limit = 1500;  // cycles allowed for any single wait

  logic        clk;
  logic        reset;
  logic        stall;
  mem_rd_req_t rd_req;
  logic        waitrequest;
  mem_rd_rsp_t rd_rsp;
  descriptor_t descriptor;
  logic        descriptor_valid;
  logic        descriptor_ready;
  logic        enable_fetch;
  logic        flush;
  desc_addr_t  new_location;
  logic        load_new_location;
  timeout_t    descriptor_timeout;
  logic        enable_timeout;
  fifo_count_t outstanding_reads;
  fifo_count_t descriptor_fill_level;
  logic        fetch_idle;

  logic [31:0] lfsr;
  int          ready_mode;           // 0 held low, 1 random, 2 held high
  int          errors;
  int          checks;
  int          tests_run;
  desc_word_t  image [desc_addr_t];  // shadow copy of the memory model contents
  descriptor_t got [$];              // everything the dispatcher accepted
  descriptor_t expected [$];

  desc_fetch_top dut0 (.*);

  tb_mem_model mem0
  (
    .clk(clk), .stall(stall), .rd_req(rd_req), .waitrequest(waitrequest), .rd_rsp(rd_rsp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ********************
  // random stimulus
  // ********************

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bit(output logic b);
    lfsr = galois_step(lfsr);  // one step for every bit taken
    b    = lfsr[0];
  endtask

  always @(posedge clk)
  begin
    logic b;
    #0.5;
    random_bit(b);
    stall = b;
    if (ready_mode == 1)
    begin
      random_bit(b);
      descriptor_ready = b;
    end
    else
      descriptor_ready = (ready_mode == 2);
  end

  // the dispatcher side, a transfer is valid and ready at the edge
  always @(posedge clk)
    if (descriptor_valid & descriptor_ready)
      got.push_back(descriptor);

  // ********************
  // compare tasks
  // ********************

  task automatic compare_descriptor(input string test, input descriptor_t exp,
                                    input descriptor_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic compare_count(input string test, input fifo_count_t exp, input fifo_count_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic compare_flag(input string test, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", test, exp, act);
    end
  endtask

  task automatic compare_total(input string test, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("FAIL %s: expected %0d descriptors, actual %0d", test, exp, act);
    end
  endtask

  // ********************
  // memory image and walk
  // ********************

  task automatic put_desc(input desc_addr_t addr, input desc_addr_t next, input logic owned,
                          input block_count_t size, input logic first);
    descriptor_t d;
    d.next_descriptor = next;
    d.source          = addr ^ 32'h00ff_0000;
    d.length          = {16'h0, addr[15:0]} + 32'd64;
    d.control         = addr[18:4];
    d.owned_by_hw     = owned;
    d.block_size      = size;
    d.format          = {7'h15, first};  // upper bits only pass through
    image[addr] = desc_word_t'(d);
    mem0.write_word(addr, desc_word_t'(d));
  endtask

  // first word carries the size and the link, the rest follow at the descriptor step
  task automatic put_block(input desc_addr_t addr, input block_count_t size, input desc_addr_t next);
    put_desc(addr, next, 1'b1, size, 1'b1);
    for (int i = 1; i <= int'(size); i++)
      put_desc(addr + desc_addr_t'(i * `DF_DESC_BYTES), addr, 1'b1, '0, 1'b0);
  endtask

  task automatic put_end(input desc_addr_t addr);
    put_desc(addr, addr + 32'h100, 1'b0, '0, 1'b1);  // not owned, so the chain stops here
  endtask

  task automatic walk_chain(input desc_addr_t start);
    desc_addr_t  addr;
    descriptor_t first;
    descriptor_t d;
    expected.delete();
    addr = start;
    for (int blocks = 0; blocks < 16; blocks++)
    begin
      first = descriptor_t'(image[addr]);
      if (!first.owned_by_hw)
        break;
      expected.push_back(first);
      for (int i = 1; i <= int'(first.block_size); i++)
      begin
        d = descriptor_t'(image[addr + desc_addr_t'(i * `DF_DESC_BYTES)]);
        if (d.owned_by_hw)
          expected.push_back(d);  // unowned words inside a block are skipped
      end
      addr = first.next_descriptor;
    end
  endtask

  task automatic check_stream(input string test);
    compare_total(test, expected.size(), got.size());
    for (int i = 0; i < expected.size() && i < got.size(); i++)
      compare_descriptor(test, expected[i], got[i]);
  endtask

  // ********************
  // sequencing
  // ********************

  task automatic step();
    @(posedge clk);
    #0.5;  // inputs change well clear of the edge
  endtask

  task automatic wait_descriptors(input string test, input int n);
    int cycles;
    cycles = 0;
    while (got.size() < n && cycles < wait_limit)
    begin
      step();
      cycles++;
    end
    if (got.size() < n)
    begin
      errors++;
      $display("%s: only %0d of %0d descriptors arrived in time", test, got.size(), n);
    end
  endtask

  task automatic wait_idle(input string test);
    int cycles;
    cycles = 0;
    while (!fetch_idle && cycles < wait_limit)
    begin
      step();
      cycles++;
    end
    if (!fetch_idle)
    begin
      errors++;
      $display("%s: the engine never went idle", test);
    end
  endtask

  task automatic wait_drained(input string test);
    int cycles;
    cycles = 0;
    while (outstanding_reads != '0 && cycles < wait_limit)
    begin
      step();
      cycles++;
    end
    if (outstanding_reads != '0)
    begin
      errors++;
      $display("%s: reads still outstanding after %0d cycles", test, wait_limit);
    end
  endtask

  task automatic wait_buffered(input string test);
    int cycles;
    cycles = 0;
    while (descriptor_fill_level == '0 && cycles < wait_limit)
    begin
      step();
      cycles++;
    end
    if (descriptor_fill_level == '0)
    begin
      errors++;
      $display("%s: nothing was buffered while the dispatcher was stalled", test);
    end
  endtask

  // stop, flush, let late responses land, then start a fresh walk at start
  task automatic restart(input string test, input desc_addr_t start);
    enable_fetch = 1'b0;
    step();
    flush = 1'b1;
    step();
    flush = 1'b0;
    wait_drained(test);
    got.delete();
    new_location      = start;
    load_new_location = 1'b1;
    step();
    load_new_location = 1'b0;
    enable_fetch      = 1'b1;
    step();
  endtask

  // ********************
  // tests
  // ********************

  task automatic test_single_chain();
    tests_run++;
    ready_mode     = 1;
    enable_timeout = 1'b0;
    put_block(32'h1000, 8'd0, 32'h2000);
    put_block(32'h2000, 8'd0, 32'h3000);
    put_block(32'h3000, 8'd0, 32'h4000);
    put_end(32'h4000);
    walk_chain(32'h1000);
    restart("single_chain", 32'h1000);
    wait_descriptors("single_chain", expected.size());
    wait_idle("single_chain");
    repeat (20) step();  // room for a duplicate to show up
    check_stream("single_chain");
    compare_flag("single_chain", 1'b1, fetch_idle);
  endtask

  task automatic test_multi_block();
    tests_run++;
    ready_mode     = 1;
    enable_timeout = 1'b0;
    put_block(32'h5000, 8'd5, 32'h6000);
    put_block(32'h6000, 8'd0, 32'h7000);
    put_end(32'h7000);
    walk_chain(32'h5000);
    restart("multi_block", 32'h5000);
    wait_descriptors("multi_block", expected.size());
    wait_idle("multi_block");
    repeat (20) step();
    check_stream("multi_block");
  endtask

  task automatic test_retry();
    logic idle_seen;
    tests_run++;
    ready_mode         = 1;
    enable_timeout     = 1'b1;
    descriptor_timeout = 16'd20;
    put_end(32'h8000);
    put_end(32'h9000);
    restart("retry", 32'h8000);
    idle_seen = 1'b0;
    repeat (200)
    begin
      step();
      idle_seen = idle_seen | fetch_idle;  // retrying never counts as idle
    end
    compare_flag("retry", 1'b0, idle_seen);
    compare_total("retry", 0, got.size());
    put_block(32'h8000, 8'd0, 32'h9000);  // host hands the block over, no reload
    walk_chain(32'h8000);
    wait_descriptors("retry", expected.size());
    repeat (20) step();
    check_stream("retry");
  endtask

  task automatic test_reload();
    tests_run++;
    ready_mode     = 1;
    enable_timeout = 1'b0;
    put_end(32'ha000);
    restart("reload", 32'ha000);
    wait_idle("reload");
    compare_total("reload", 0, got.size());
    put_block(32'hb000, 8'd2, 32'hc000);
    put_end(32'hc000);
    walk_chain(32'hb000);
    new_location      = 32'hb000;
    load_new_location = 1'b1;
    step();
    load_new_location = 1'b0;
    step();
    wait_descriptors("reload", expected.size());
    wait_idle("reload");
    repeat (20) step();
    check_stream("reload");
  endtask

  task automatic test_back_pressure();
    tests_run++;
    ready_mode     = 0;
    enable_timeout = 1'b0;
    put_block(32'hd000, 8'd11, 32'he000);
    put_block(32'he000, 8'd11, 32'he800);  // a second block lets the walk outrun the FIFO
    put_end(32'he800);
    walk_chain(32'hd000);
    restart("back_pressure", 32'hd000);
    repeat (300)
    begin
      step();
      if (int'(descriptor_fill_level) > 16)
      begin
        errors++;
        $display("back_pressure: fill level %0d is above the FIFO depth", descriptor_fill_level);
      end
      if (int'(outstanding_reads) + int'(descriptor_fill_level) > 16)
      begin
        errors++;
        $display("back_pressure: %0d reads in flight with %0d buffered could overflow the FIFO",
                 outstanding_reads, descriptor_fill_level);
      end
    end
    compare_total("back_pressure", 0, got.size());
    ready_mode = 2;
    wait_descriptors("back_pressure", expected.size());
    wait_idle("back_pressure");
    repeat (20) step();
    check_stream("back_pressure");
  endtask

  task automatic test_disable_flush();
    tests_run++;
    ready_mode     = 2;
    enable_timeout = 1'b0;
    put_block(32'hf000, 8'd15, 32'h1_0000);
    put_end(32'h1_0000);
    walk_chain(32'hf000);
    restart("disable_flush", 32'hf000);
    wait_descriptors("disable_flush", 3);
    ready_mode = 0;  // the dispatcher stalls so words pile up in the FIFO
    step();
    wait_buffered("disable_flush");
    enable_fetch = 1'b0;  // mid-block, reads may still be on their way
    step();
    flush = 1'b1;
    step();
    flush = 1'b0;
    wait_drained("disable_flush");
    repeat (5) step();
    for (int i = 0; i < got.size() && i < expected.size(); i++)
      compare_descriptor("disable_flush", expected[i], got[i]);
    compare_count("disable_flush", '0, descriptor_fill_level);
    compare_flag("disable_flush", 1'b0, descriptor_valid);
    compare_count("disable_flush", '0, outstanding_reads);
  endtask

  // ********************
  // run control
  // ********************

  initial
  begin
    lfsr               = 32'h17c5_fc1e;
    ready_mode         = 1;
    errors             = 0;
    checks             = 0;
    tests_run          = 0;
    stall              = 1'b0;
    descriptor_ready   = 1'b0;
    enable_fetch       = 1'b0;
    flush              = 1'b0;
    new_location       = '0;
    load_new_location  = 1'b0;
    descriptor_timeout = '0;
    enable_timeout     = 1'b0;
    reset              = 1'b1;
    repeat (10) @(posedge clk);
    #0.5;
    reset = 1'b0;
    step();
    compare_flag("reset", 1'b1, fetch_idle);
    compare_flag("reset", 1'b0, rd_req.read);
    compare_flag("reset", 1'b0, descriptor_valid);
    compare_count("reset", '0, outstanding_reads);
    test_single_chain();
    test_multi_block();
    test_retry();
    test_reload();
    test_back_pressure();
    test_disable_flush();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // hard stop, sized generously against the longest test
  initial
  begin
    repeat (num_tests * 2000) @(posedge clk);
    $display("watchdog: run stopped after %0d cycles without finishing", num_tests * 2000);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/desc_fetch_pkg.sv
verilog/desc_fifo.sv
verilog/desc_fetch_ctrl.sv
verilog/desc_fetch_top.sv
verification/tb_mem_model.sv
verification/desc_fetch_tb.sv

// File: Makefile
# Verilator build and run of the descriptor fetch engine testbench

VERILATOR ?= verilator
TOP       ?= desc_fetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
